/* lsq_pkg.sv */
/*
 * Shared widths and bus structs for the load/store queue.
 * Every unit and the top level pull these in with a wildcard import.
 */

package lsq_pkg;

	// ***********************************************************************
	// widths
	// ***********************************************************************
	localparam int ADDR_W    = 32;
	localparam int DATA_W    = 64;
	localparam int ROB_IDX_W = 6;
	localparam int PRF_TAG_W = 6;

	typedef logic [ADDR_W-1:0]    addr_t;
	typedef logic [DATA_W-1:0]    data_t;
	typedef logic [ROB_IDX_W-1:0] rob_idx_t;
	typedef logic [PRF_TAG_W-1:0] prf_tag_t;

	// ***********************************************************************
	// buses between the queue and the core / cache
	// ***********************************************************************

	// load in execute
	typedef struct packed {
		logic     vld;
		addr_t    addr;
		rob_idx_t rob_idx;
		prf_tag_t dest_tag;
	} ld_req_t;

	// store in execute, slot index travels beside it
	typedef struct packed {
		logic     vld;
		addr_t    addr;
		data_t    data;
		rob_idx_t rob_idx;
		prf_tag_t dest_tag;
	} st_exec_t;

	// retired store going to the data cache
	typedef struct packed {
		logic  en;
		addr_t addr;
		data_t data;
	} dc_st_t;

	// fill coming back from the miss-status unit
	typedef struct packed {
		logic  vld;
		addr_t addr;
		data_t data;
	} dc_fill_t;

	// load result to writeback
	typedef struct packed {
		logic     done;
		data_t    data;
		rob_idx_t rob_idx;
		prf_tag_t dest_tag;
	} ld_cmpl_t;

endpackage

/* lsq_store_queue.sv */
/*
 * Store queue. Allocates an entry at dispatch, captures address and data
 * when the store executes, and marks entries ready as the reorder buffer
 * retires them. Retired stores drain to the data cache in program order,
 * one per cache acknowledge. Entry contents are exported for the load
 * scan logic.
 */

`timescale 1ns/1ps

module lsq_store_queue
	import lsq_pkg::*;
#(
	parameter int SQ_ENTRIES = 8,
	parameter int SQ_IDX_W   = $clog2(SQ_ENTRIES)
) (
	input  logic                         clk,
	input  logic                         rst,
	input  logic                         dp_en_i,
	input  st_exec_t                     st_exec_i,
	input  logic [SQ_IDX_W-1:0]          st_idx_i,
	input  logic                         rob_st_retire_en_i,
	input  logic                         dc_st_ack_i,
	output addr_t [SQ_ENTRIES-1:0]       sq_addr_o,
	output data_t [SQ_ENTRIES-1:0]       sq_data_o,
	output logic  [SQ_ENTRIES-1:0]       sq_addr_vld_o,
	output logic  [SQ_IDX_W-1:0]         sq_head_o,
	output logic  [SQ_IDX_W:0]           sq_tail_o,
	output logic                         sq_full_o,
	output dc_st_t                       dc_st_o
);

	// pointers carry a wrap bit above the index
	logic [SQ_IDX_W:0]      head_q;
	logic [SQ_IDX_W:0]      rhead_q;
	logic [SQ_IDX_W:0]      tail_q;
	logic [SQ_IDX_W-1:0]    head;
	logic [SQ_IDX_W-1:0]    rhead;
	logic [SQ_IDX_W-1:0]    tail;

	addr_t [SQ_ENTRIES-1:0] st_addr_r;
	data_t [SQ_ENTRIES-1:0] st_data_r;
	logic  [SQ_ENTRIES-1:0] addr_vld_r;
	logic  [SQ_ENTRIES-1:0] addr_vld_nxt;
	logic  [SQ_ENTRIES-1:0] rtr_rdy_r;
	logic  [SQ_ENTRIES-1:0] rtr_rdy_nxt;

	logic                   drain_en;
	logic                   pop;

	assign head  = head_q[SQ_IDX_W-1:0];
	assign rhead = rhead_q[SQ_IDX_W-1:0];
	assign tail  = tail_q[SQ_IDX_W-1:0];

	// ***********************************************************************
	// drain to the data cache
	// ***********************************************************************

	// head is presented once its retire-ready bit is set
	assign drain_en = rtr_rdy_r[head];
	assign pop      = drain_en & dc_st_ack_i;

	assign dc_st_o.en   = drain_en;
	assign dc_st_o.addr = st_addr_r[head];
	assign dc_st_o.data = st_data_r[head];

	// ***********************************************************************
	// entry state
	// ***********************************************************************
	always_comb begin
		addr_vld_nxt = addr_vld_r;
		if (dp_en_i)
			addr_vld_nxt[tail] = 1'b0;
		if (st_exec_i.vld)
			addr_vld_nxt[st_idx_i] = 1'b1;
		if (pop)
			addr_vld_nxt[head] = 1'b0;
	end

	always_comb begin
		rtr_rdy_nxt = rtr_rdy_r;
		if (rob_st_retire_en_i)
			rtr_rdy_nxt[rhead] = 1'b1;
		if (pop)
			rtr_rdy_nxt[head] = 1'b0;
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			head_q     <= '0;
			rhead_q    <= '0;
			tail_q     <= '0;
			addr_vld_r <= '0;
			rtr_rdy_r  <= '0;
		end else begin
			if (pop)
				head_q <= head_q + 1'b1;
			if (rob_st_retire_en_i)
				rhead_q <= rhead_q + 1'b1;
			if (dp_en_i)
				tail_q <= tail_q + 1'b1;
			addr_vld_r <= addr_vld_nxt;
			rtr_rdy_r  <= rtr_rdy_nxt;
		end
	end

	// payload written at execute
	always_ff @(posedge clk) begin
		if (st_exec_i.vld) begin
			st_addr_r[st_idx_i] <= st_exec_i.addr;
			st_data_r[st_idx_i] <= st_exec_i.data;
		end
	end

	// ***********************************************************************
	// outputs to the scan logic and dispatch
	// ***********************************************************************
	assign sq_addr_o     = st_addr_r;
	assign sq_data_o     = st_data_r;
	assign sq_addr_vld_o = addr_vld_r;
	assign sq_head_o     = head;
	assign sq_tail_o     = tail_q;

	// same slot, different lap
	assign sq_full_o = (head == tail) && (head_q[SQ_IDX_W] != tail_q[SQ_IDX_W]);

endmodule

/* lsq_store_scan.sv */
/*
 * Store scan. Holds back load issue until all stores older than the load
 * have a known address, and searches the older stores for the youngest
 * one whose address matches the load in execute. Purely combinational.
 */

`timescale 1ns/1ps

module lsq_store_scan
	import lsq_pkg::*;
#(
	parameter int SQ_ENTRIES = 8,
	parameter int SQ_IDX_W   = $clog2(SQ_ENTRIES)
) (
	input  addr_t [SQ_ENTRIES-1:0]       sq_addr_i,
	input  data_t [SQ_ENTRIES-1:0]       sq_data_i,
	input  logic  [SQ_ENTRIES-1:0]       sq_addr_vld_i,
	input  logic  [SQ_IDX_W-1:0]         sq_head_i,
	input  logic  [SQ_IDX_W-1:0]         sq_tail_i,
	input  logic                         sq_full_i,
	input  logic  [SQ_IDX_W-1:0]         rs_ld_position_i,
	input  logic  [SQ_IDX_W-1:0]         ex_ld_position_i,
	input  ld_req_t                      ld_req_i,
	input  logic                         lq_full_i,
	input  logic                         dc_mshr_stall_i,
	output logic                         ld_iss_en_o,
	output logic                         fwd_vld_o,
	output data_t                        fwd_data_o
);

	logic  iss_ok;
	logic  fwd_lo_vld;
	logic  fwd_hi_vld;
	data_t fwd_lo_data;
	data_t fwd_hi_data;

	// slot lies between head and the load position, i.e. holds an older store
	function automatic logic older(input logic [SQ_IDX_W-1:0] slot,
			input logic [SQ_IDX_W-1:0] pos);
		logic flat;
		flat = (pos >= sq_head_i) && (!sq_full_i || (pos != sq_tail_i));
		if (flat)
			return (slot >= sq_head_i) && (slot < pos);
		// range wraps past the last slot
		return (slot < pos) || (slot >= sq_head_i);
	endfunction

	// ***********************************************************************
	// issue gate
	// ***********************************************************************
	always_comb begin
		iss_ok = 1'b1;
		for (int i = 0; i < SQ_ENTRIES; i++) begin
			if (older(SQ_IDX_W'(i), rs_ld_position_i) && !sq_addr_vld_i[i])
				iss_ok = 1'b0;
		end
	end

	assign ld_iss_en_o = iss_ok && !lq_full_i && !dc_mshr_stall_i;

	// ***********************************************************************
	// forwarding
	// ***********************************************************************

	// slots below the load position are always younger than those above head
	always_comb begin
		fwd_lo_vld  = 1'b0;
		fwd_hi_vld  = 1'b0;
		fwd_lo_data = '0;
		fwd_hi_data = '0;
		for (int i = 0; i < SQ_ENTRIES; i++) begin
			if (ld_req_i.vld && sq_addr_vld_i[i] && (sq_addr_i[i] == ld_req_i.addr)
					&& older(SQ_IDX_W'(i), ex_ld_position_i)) begin
				if (SQ_IDX_W'(i) < ex_ld_position_i) begin
					fwd_lo_vld  = 1'b1;
					fwd_lo_data = sq_data_i[i];
				end else begin
					fwd_hi_vld  = 1'b1;
					fwd_hi_data = sq_data_i[i];
				end
			end
		end
	end

	assign fwd_vld_o  = fwd_lo_vld | fwd_hi_vld;
	assign fwd_data_o = fwd_lo_vld ? fwd_lo_data : fwd_hi_data;

endmodule

/* lsq_miss_queue.sv */
/*
 * Load completion and miss queue. A load that hits the cache or gets a
 * forwarded store value completes in the cycle it is presented. Misses
 * are queued, capture their fill data, and complete strictly in queue
 * order once the fill for their address has arrived.
 */

`timescale 1ns/1ps

module lsq_miss_queue
	import lsq_pkg::*;
#(
	parameter int LQ_ENTRIES = 4,
	parameter int LQ_IDX_W   = $clog2(LQ_ENTRIES)
) (
	input  logic     clk,
	input  logic     rst,
	input  ld_req_t  ld_req_i,
	input  logic     fwd_vld_i,
	input  data_t    fwd_data_i,
	input  logic     dc_hit_i,
	input  data_t    dc_data_i,
	input  dc_fill_t dc_fill_i,
	output logic     lq_full_o,
	output addr_t    dc_ld_addr_o,
	output logic     dc_ld_miss_o,
	output ld_cmpl_t ld_direct_o,
	output ld_cmpl_t ld_queued_o
);

	logic [LQ_IDX_W:0]         head_q;
	logic [LQ_IDX_W:0]         tail_q;
	logic [LQ_IDX_W-1:0]       head;
	logic [LQ_IDX_W-1:0]       tail;

	addr_t    [LQ_ENTRIES-1:0] lq_addr_r;
	data_t    [LQ_ENTRIES-1:0] lq_data_r;
	rob_idx_t [LQ_ENTRIES-1:0] lq_rob_idx_r;
	prf_tag_t [LQ_ENTRIES-1:0] lq_dest_tag_r;
	logic     [LQ_ENTRIES-1:0] lq_rdy_r;
	logic     [LQ_ENTRIES-1:0] lq_rdy_nxt;
	logic     [LQ_ENTRIES-1:0] fill_hit;

	logic                      lq_empty;
	logic                      ld_direct;
	logic                      ld_miss;
	logic                      head_cmpl;

	assign head = head_q[LQ_IDX_W-1:0];
	assign tail = tail_q[LQ_IDX_W-1:0];

	assign lq_empty  = (head_q == tail_q);
	assign lq_full_o = (head == tail) && (head_q[LQ_IDX_W] != tail_q[LQ_IDX_W]);

	// ***********************************************************************
	// direct completion
	// ***********************************************************************

	// a fill in the same cycle turns a hit into a miss
	assign ld_direct = ld_req_i.vld && (dc_hit_i || fwd_vld_i) && !dc_fill_i.vld;
	assign ld_miss   = ld_req_i.vld && !ld_direct;

	assign dc_ld_addr_o = ld_req_i.addr;
	assign dc_ld_miss_o = ld_miss;

	assign ld_direct_o.done     = ld_direct;
	assign ld_direct_o.data     = fwd_vld_i ? fwd_data_i : dc_data_i;
	assign ld_direct_o.rob_idx  = ld_req_i.rob_idx;
	assign ld_direct_o.dest_tag = ld_req_i.dest_tag;

	// ***********************************************************************
	// miss queue
	// ***********************************************************************

	// first fill for an entry's address; later fills leave it alone
	always_comb begin
		for (int k = 0; k < LQ_ENTRIES; k++)
			fill_hit[k] = dc_fill_i.vld && !lq_rdy_r[k] && (lq_addr_r[k] == dc_fill_i.addr);
	end

	always_comb begin
		lq_rdy_nxt = lq_rdy_r | fill_hit;
		// new entry starts not ready, also over a stale slot
		if (ld_miss)
			lq_rdy_nxt[tail] = 1'b0;
	end

	assign head_cmpl = !lq_empty && (lq_rdy_r[head] || fill_hit[head]);

	always_ff @(posedge clk) begin
		if (rst) begin
			head_q   <= '0;
			tail_q   <= '0;
			lq_rdy_r <= '0;
		end else begin
			if (head_cmpl)
				head_q <= head_q + 1'b1;
			if (ld_miss)
				tail_q <= tail_q + 1'b1;
			lq_rdy_r <= lq_rdy_nxt;
		end
	end

	always_ff @(posedge clk) begin
		if (ld_miss) begin
			lq_addr_r[tail]     <= ld_req_i.addr;
			lq_rob_idx_r[tail]  <= ld_req_i.rob_idx;
			lq_dest_tag_r[tail] <= ld_req_i.dest_tag;
		end
		for (int k = 0; k < LQ_ENTRIES; k++) begin
			if (fill_hit[k])
				lq_data_r[k] <= dc_fill_i.data;
		end
	end

	// head completes from the fill bus or from data captured earlier
	assign ld_queued_o.done     = head_cmpl;
	assign ld_queued_o.data     = lq_rdy_r[head] ? lq_data_r[head] : dc_fill_i.data;
	assign ld_queued_o.rob_idx  = lq_rob_idx_r[head];
	assign ld_queued_o.dest_tag = lq_dest_tag_r[head];

endmodule

/* lsq_top.sv */
/*
 * Load/store queue top level. Connects the store queue, the store scan
 * logic and the load miss queue, and sets the entry counts for all three.
 */

`timescale 1ns/1ps

module lsq_top
	import lsq_pkg::*;
#(
	parameter int SQ_ENTRIES = 8,
	parameter int LQ_ENTRIES = 4,
	parameter int SQ_IDX_W   = $clog2(SQ_ENTRIES)
) (
	input  logic                 clk,
	input  logic                 rst,
	input  logic                 dp_en_i,
	input  st_exec_t             st_exec_i,
	input  logic [SQ_IDX_W-1:0]  st_idx_i,
	input  ld_req_t              ld_req_i,
	input  logic [SQ_IDX_W-1:0]  rs_ld_position_i,
	input  logic [SQ_IDX_W-1:0]  ex_ld_position_i,
	input  logic                 rob_st_retire_en_i,
	input  logic                 dc_hit_i,
	input  data_t                dc_data_i,
	input  logic                 dc_st_ack_i,
	input  logic                 dc_mshr_stall_i,
	input  dc_fill_t             dc_fill_i,
	output logic [SQ_IDX_W:0]    sq_tail_o,
	output logic                 sq_full_o,
	output logic                 ld_iss_en_o,
	output addr_t                dc_ld_addr_o,
	output logic                 dc_ld_miss_o,
	output dc_st_t               dc_st_o,
	output ld_cmpl_t             ld_direct_o,
	output ld_cmpl_t             ld_queued_o
);

	addr_t [SQ_ENTRIES-1:0] sq_addr;
	data_t [SQ_ENTRIES-1:0] sq_data;
	logic  [SQ_ENTRIES-1:0] sq_addr_vld;
	logic  [SQ_IDX_W-1:0]   sq_head;
	logic  [SQ_IDX_W:0]     sq_tail;
	logic                   sq_full;
	logic                   fwd_vld;
	data_t                  fwd_data;
	logic                   lq_full;

	assign sq_tail_o = sq_tail;
	assign sq_full_o = sq_full;

	lsq_store_queue #(
		.SQ_ENTRIES(SQ_ENTRIES)
	) store_queue_i (
		.clk                (clk),
		.rst                (rst),
		.dp_en_i            (dp_en_i),
		.st_exec_i          (st_exec_i),
		.st_idx_i           (st_idx_i),
		.rob_st_retire_en_i (rob_st_retire_en_i),
		.dc_st_ack_i        (dc_st_ack_i),
		.sq_addr_o          (sq_addr),
		.sq_data_o          (sq_data),
		.sq_addr_vld_o      (sq_addr_vld),
		.sq_head_o          (sq_head),
		.sq_tail_o          (sq_tail),
		.sq_full_o          (sq_full),
		.dc_st_o            (dc_st_o)
	);

	// scan only needs the tail slot, the wrap bit is folded into sq_full
	lsq_store_scan #(
		.SQ_ENTRIES(SQ_ENTRIES)
	) store_scan_i (
		.sq_addr_i          (sq_addr),
		.sq_data_i          (sq_data),
		.sq_addr_vld_i      (sq_addr_vld),
		.sq_head_i          (sq_head),
		.sq_tail_i          (sq_tail[SQ_IDX_W-1:0]),
		.sq_full_i          (sq_full),
		.rs_ld_position_i   (rs_ld_position_i),
		.ex_ld_position_i   (ex_ld_position_i),
		.ld_req_i           (ld_req_i),
		.lq_full_i          (lq_full),
		.dc_mshr_stall_i    (dc_mshr_stall_i),
		.ld_iss_en_o        (ld_iss_en_o),
		.fwd_vld_o          (fwd_vld),
		.fwd_data_o         (fwd_data)
	);

	lsq_miss_queue #(
		.LQ_ENTRIES(LQ_ENTRIES)
	) miss_queue_i (
		.clk                (clk),
		.rst                (rst),
		.ld_req_i           (ld_req_i),
		.fwd_vld_i          (fwd_vld),
		.fwd_data_i         (fwd_data),
		.dc_hit_i           (dc_hit_i),
		.dc_data_i          (dc_data_i),
		.dc_fill_i          (dc_fill_i),
		.lq_full_o          (lq_full),
		.dc_ld_addr_o       (dc_ld_addr_o),
		.dc_ld_miss_o       (dc_ld_miss_o),
		.ld_direct_o        (ld_direct_o),
		.ld_queued_o        (ld_queued_o)
	);

endmodule

/* lsq_assertions.sv */
/*
 * Concurrent checks on the store queue drain and allocation.
 * Attached to every lsq_store_queue instance through the bind below.
 */

`timescale 1ns/1ps

module lsq_assertions
	import lsq_pkg::*;
#(
	parameter int SQ_IDX_W = 3
) (
	input logic                clk,
	input logic                rst,
	input logic                dp_en_i,
	input logic                sq_full_o,
	input logic                dc_st_ack_i,
	input logic [SQ_IDX_W-1:0] sq_head_o,
	input dc_st_t              dc_st_o
);

	// no allocation into a full queue
	no_dispatch_when_full: assert property (@(posedge clk) disable iff (rst)
		!(dp_en_i && sq_full_o))
		else $error("store dispatched while the store queue is full");

	// drain word held until the cache takes it
	drain_held_until_ack: assert property (@(posedge clk) disable iff (rst)
		(dc_st_o.en && !dc_st_ack_i) |=> (dc_st_o.en && $stable(dc_st_o)
			&& $stable(sq_head_o)))
		else $error("drain word dropped or changed without an acknowledge");

	drain_idle_after_reset: assert property (@(posedge clk)
		rst |=> !dc_st_o.en)
		else $error("drain enable high in the cycle after reset");

endmodule

bind lsq_store_queue lsq_assertions #(
	.SQ_IDX_W(SQ_IDX_W)
) sq_checks_i (
	.clk         (clk),
	.rst         (rst),
	.dp_en_i     (dp_en_i),
	.sq_full_o   (sq_full_o),
	.dc_st_ack_i (dc_st_ack_i),
	.sq_head_o   (sq_head_o),
	.dc_st_o     (dc_st_o)
);

/* tb_lsq.sv */
/*
 * Testbench for the load/store queue. Random dispatch, execute, retire,
 * load and cache traffic from a fixed seed, checked every cycle against
 * a reference store queue, miss queue and a small cache model.
 * Prints one line per test and a closing count line.
 */

`timescale 1ns/1ps

module tb_lsq;
	import lsq_pkg::*;

	localparam int    SQ_N        = 8;
	localparam int    LQ_N        = 4;
	localparam int    SQ_W        = $clog2(SQ_N);
	localparam int    N_ADDR      = 4;
	localparam int    N_TESTS     = 4;
	localparam int    TEST_CYCLES = 2000;
	localparam longint TIMEOUT_NS = (N_TESTS * TEST_CYCLES + 10) * 8 + 2000;

	typedef struct packed {
		logic  vld;
		logic  rtr;
		addr_t addr;
		data_t data;
	} st_ent_t;

	typedef struct packed {
		logic     rdy;
		addr_t    addr;
		data_t    data;
		rob_idx_t rob_idx;
		prf_tag_t dest_tag;
	} miss_ent_t;

	logic          clk;
	logic          rst;
	logic          dp_en;
	st_exec_t      st_exec;
	logic [SQ_W-1:0] st_idx;
	ld_req_t       ld_req;
	logic [SQ_W-1:0] rs_pos;
	logic [SQ_W-1:0] ex_pos;
	logic          retire_en;
	logic          dc_hit;
	data_t         dc_data;
	logic          dc_st_ack;
	logic          mshr_stall;
	dc_fill_t      dc_fill;
	logic [SQ_W:0] sq_tail;
	logic          sq_full;
	logic          ld_iss_en;
	addr_t         dc_ld_addr;
	logic          dc_ld_miss;
	dc_st_t        dc_st;
	ld_cmpl_t      ld_direct;
	ld_cmpl_t      ld_queued;

	// reference state
	st_ent_t       sq_m [SQ_N];
	int            m_head;
	int            m_rhead;
	int            m_tail;
	miss_ent_t     mq [$];
	logic          cache_vld [N_ADDR];
	data_t         cache_data [N_ADDR];
	int            checks;
	int            errors;

	lsq_top #(
		.SQ_ENTRIES(SQ_N),
		.LQ_ENTRIES(LQ_N)
	) lsq_top_i (
		.clk                (clk),
		.rst                (rst),
		.dp_en_i            (dp_en),
		.st_exec_i          (st_exec),
		.st_idx_i           (st_idx),
		.ld_req_i           (ld_req),
		.rs_ld_position_i   (rs_pos),
		.ex_ld_position_i   (ex_pos),
		.rob_st_retire_en_i (retire_en),
		.dc_hit_i           (dc_hit),
		.dc_data_i          (dc_data),
		.dc_st_ack_i        (dc_st_ack),
		.dc_mshr_stall_i    (mshr_stall),
		.dc_fill_i          (dc_fill),
		.sq_tail_o          (sq_tail),
		.sq_full_o          (sq_full),
		.ld_iss_en_o        (ld_iss_en),
		.dc_ld_addr_o       (dc_ld_addr),
		.dc_ld_miss_o       (dc_ld_miss),
		.dc_st_o            (dc_st),
		.ld_direct_o        (ld_direct),
		.ld_queued_o        (ld_queued)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// few addresses, so stores and loads collide often
	function automatic addr_t addr_of(input int i);
		return 32'h0000_1000 + addr_t'(i << 3);
	endfunction

	function automatic data_t rand_data();
		return {$urandom, $urandom};
	endfunction

	task automatic check(input string name, input logic [63:0] exp, input logic [63:0] act);
		checks++;
		if (exp !== act) begin
			errors++;
			$display("[FAIL] %0t %s expected %h actual %h", $time, name, exp, act);
		end
	endtask

	// ***********************************************************************
	// one clock cycle: drive, check, advance the model
	// ***********************************************************************
	task automatic step(input int ld_pct, input int fill_pct, input int ack_pct);
		int        cnt;
		int        lead;
		int        k;
		int        a;
		int        slot;
		logic      exp_fwd;
		data_t     exp_fdata;
		logic      exp_iss;
		logic      exp_direct;
		logic      head_done;
		data_t     head_data;
		st_ent_t   e;
		miss_ent_t me;
		@(negedge clk);
		cnt = m_tail - m_head;
		dp_en = (cnt < SQ_N) && ($urandom % 100 < 40);

		st_exec = '0;
		k = $urandom % SQ_N;
		slot = (m_head + k) % SQ_N;
		st_idx = SQ_W'(slot);
		if (k < cnt && !sq_m[slot].vld && $urandom % 2) begin
			st_exec.vld = 1'b1;
			st_exec.addr = addr_of($urandom % N_ADDR);
			st_exec.data = rand_data();
			st_exec.rob_idx = rob_idx_t'($urandom);
			st_exec.dest_tag = prf_tag_t'($urandom);
		end

		retire_en = (m_rhead < m_tail) && sq_m[m_rhead % SQ_N].vld && ($urandom % 2);
		dc_st_ack = ($urandom % 100) < ack_pct;
		mshr_stall = ($urandom % 8) == 0;

		// load being scheduled
		k = $urandom % (cnt + 1);
		if (cnt == SQ_N && k == 0)
			k = SQ_N;
		rs_pos = SQ_W'((m_head + k) % SQ_N);
		exp_iss = (mq.size() < LQ_N) && !mshr_stall;
		for (int j = 0; j < k; j++)
			if (!sq_m[(m_head + j) % SQ_N].vld)
				exp_iss = 1'b0;

		// load in execute sees only older stores with known addresses
		lead = 0;
		while (lead < cnt && sq_m[(m_head + lead) % SQ_N].vld)
			lead++;
		a = $urandom % N_ADDR;
		ld_req = '0;
		ld_req.addr = addr_of(a);
		ex_pos = SQ_W'($urandom);
		exp_fwd = 1'b0;
		exp_fdata = '0;
		if (mq.size() < LQ_N && ($urandom % 100) < ld_pct && !(cnt == SQ_N && lead == 0)) begin
			k = (cnt == SQ_N) ? 1 + $urandom % lead : $urandom % (lead + 1);
			ex_pos = SQ_W'((m_head + k) % SQ_N);
			ld_req.vld = 1'b1;
			ld_req.rob_idx = rob_idx_t'($urandom);
			ld_req.dest_tag = prf_tag_t'($urandom);
			for (int j = 0; j < k; j++) begin
				e = sq_m[(m_head + j) % SQ_N];
				if (e.addr == ld_req.addr) begin
					exp_fwd = 1'b1;
					exp_fdata = e.data;
				end
			end
		end
		dc_hit = cache_vld[a];
		dc_data = cache_data[a];

		dc_fill = '0;
		if (($urandom % 100) < fill_pct) begin
			dc_fill.vld = 1'b1;
			dc_fill.data = rand_data();
			if (mq.size() > 0 && $urandom % 2)
				dc_fill.addr = mq[$urandom % mq.size()].addr;
			else
				dc_fill.addr = addr_of($urandom % N_ADDR);
		end

		#2;
		check("sq_tail_o", 64'(m_tail % (2 * SQ_N)), 64'(sq_tail));
		check("sq_full_o", 64'(cnt == SQ_N), 64'(sq_full));
		check("ld_iss_en_o", 64'(exp_iss), 64'(ld_iss_en));

		exp_direct = ld_req.vld && (dc_hit || exp_fwd) && !dc_fill.vld;
		check("ld_direct_o.done", 64'(exp_direct), 64'(ld_direct.done));
		if (exp_direct) begin
			check("ld_direct_o.data", exp_fwd ? exp_fdata : dc_data, ld_direct.data);
			check("ld_direct_o.rob_idx", 64'(ld_req.rob_idx), 64'(ld_direct.rob_idx));
			check("ld_direct_o.dest_tag", 64'(ld_req.dest_tag), 64'(ld_direct.dest_tag));
		end
		check("dc_ld_miss_o", 64'(ld_req.vld && !exp_direct), 64'(dc_ld_miss));
		if (ld_req.vld)
			check("dc_ld_addr_o", 64'(ld_req.addr), 64'(dc_ld_addr));

		e = sq_m[m_head % SQ_N];
		check("dc_st_o.en", 64'(cnt > 0 && e.rtr), 64'(dc_st.en));
		if (cnt > 0 && e.rtr) begin
			check("dc_st_o.addr", 64'(e.addr), 64'(dc_st.addr));
			check("dc_st_o.data", e.data, dc_st.data);
		end

		head_done = 1'b0;
		head_data = dc_fill.data;
		if (mq.size() > 0) begin
			head_done = mq[0].rdy || (dc_fill.vld && dc_fill.addr == mq[0].addr);
			if (mq[0].rdy)
				head_data = mq[0].data;
		end
		check("ld_queued_o.done", 64'(head_done), 64'(ld_queued.done));
		if (head_done) begin
			check("ld_queued_o.data", head_data, ld_queued.data);
			check("ld_queued_o.rob_idx", 64'(mq[0].rob_idx), 64'(ld_queued.rob_idx));
			check("ld_queued_o.dest_tag", 64'(mq[0].dest_tag), 64'(ld_queued.dest_tag));
			void'(mq.pop_front());
		end

		// model state after the coming edge
		if (dc_fill.vld) begin
			for (int j = 0; j < mq.size(); j++) begin
				if (!mq[j].rdy && mq[j].addr == dc_fill.addr) begin
					mq[j].rdy = 1'b1;
					mq[j].data = dc_fill.data;
				end
			end
			cache_vld[dc_fill.addr[4:3]] = 1'b1;
			cache_data[dc_fill.addr[4:3]] = dc_fill.data;
		end
		if (ld_req.vld && !exp_direct) begin
			me = '0;
			me.addr = ld_req.addr;
			me.rob_idx = ld_req.rob_idx;
			me.dest_tag = ld_req.dest_tag;
			mq.push_back(me);
		end
		if (dp_en) begin
			sq_m[m_tail % SQ_N] = '0;
			m_tail++;
		end
		if (st_exec.vld) begin
			sq_m[st_idx].vld = 1'b1;
			sq_m[st_idx].addr = st_exec.addr;
			sq_m[st_idx].data = st_exec.data;
		end
		if (retire_en) begin
			sq_m[m_rhead % SQ_N].rtr = 1'b1;
			m_rhead++;
		end
		if (cnt > 0 && e.rtr && dc_st_ack) begin
			sq_m[m_head % SQ_N] = '0;
			m_head++;
			if (cache_vld[e.addr[4:3]])
				cache_data[e.addr[4:3]] = e.data;
		end
		// occasional eviction keeps misses coming
		if ($urandom % 4 == 0)
			cache_vld[$urandom % N_ADDR] = 1'b0;
	endtask

	task automatic run_test(input string name, input int ld_pct, input int fill_pct,
			input int ack_pct);
		int chk0;
		int err0;
		chk0 = checks;
		err0 = errors;
		repeat (TEST_CYCLES)
			step(ld_pct, fill_pct, ack_pct);
		$display("test %s: %0d checks, %0d errors", name, checks - chk0, errors - err0);
	endtask

	initial begin
		void'($urandom(32'h31a04e5d));
		rst = 1'b1;
		dp_en = 1'b0;
		st_exec = '0;
		st_idx = '0;
		ld_req = '0;
		rs_pos = '0;
		ex_pos = '0;
		retire_en = 1'b0;
		dc_hit = 1'b0;
		dc_data = '0;
		dc_st_ack = 1'b0;
		mshr_stall = 1'b0;
		dc_fill = '0;
		m_head = 0;
		m_rhead = 0;
		m_tail = 0;
		checks = 0;
		errors = 0;
		for (int i = 0; i < SQ_N; i++)
			sq_m[i] = '0;
		for (int i = 0; i < N_ADDR; i++) begin
			cache_vld[i] = 1'b0;
			cache_data[i] = rand_data();
		end
		repeat (2) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;

		run_test("mixed traffic", 40, 25, 60);
		run_test("drain backpressure", 30, 20, 15);
		run_test("miss heavy", 70, 10, 70);
		run_test("fill heavy", 50, 60, 50);

		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0)
			$display("All tests passed");
		else
			$display("Some tests failed");
		$finish;
	end

	// watchdog sized from the test lengths
	initial begin
		#(TIMEOUT_NS);
		$display("timeout: the tests did not finish in the expected time");
		$display("Some tests failed");
		$finish;
	end

endmodule

/* sim.f */
lsq_pkg.sv
lsq_store_queue.sv
lsq_store_scan.sv
lsq_miss_queue.sv
lsq_top.sv
lsq_assertions.sv
tb_lsq.sv
